//--- logic/host_api_cfg.svh
`ifndef HOST_API_CFG_SVH
`define HOST_API_CFG_SVH

// Byte address width on the host side, word addresses are one bit narrower
`define API_ADDR_BITS 23

// Host data bytes waiting to be packed
`define API_BYTE_FIFO_DEPTH 8

// Packed words waiting for the SDRAM controller
`define API_WORD_FIFO_DEPTH 4

// Register whose read returns ev_reg and takes the interrupt snapshot
`define API_EV_REG_ADDR 1

`endif

//--- logic/host_api_pkg.sv
`default_nettype none
`include "host_api_cfg.svh"

package host_api_pkg;

    typedef enum logic [7:0] {
        CMD_READ_MEM  = 8'd0,
        CMD_WRITE_MEM = 8'd1,
        CMD_READ_REG  = 8'd2,
        CMD_WRITE_REG = 8'd3
    } cmd_e;

    typedef enum logic [1:0] {
        IDLE,
        CMD,
        ADDR,
        DATA
    } api_state_e;

    // One SDRAM write, word addressed
    typedef struct packed {
        logic [`API_ADDR_BITS-2:0] addr;
        logic [15:0]               data;
    } ram_write_t;

endpackage

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr]; // Head entry is always presented

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/api_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "host_api_cfg.svh"

module api_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic [7:0]                rd_data,
    input  logic                      rd_valid,
    output logic                      host_ready,
    input  logic                      byte_fifo_full,
    output logic                      byte_push,
    output logic [7:0]                byte_data,
    output logic                      packer_load,
    output logic [`API_ADDR_BITS-2:0] word_base,
    output logic [7:0]                wr_data,
    output logic                      wr_valid,
    input  logic                      wr_ready,
    output logic [31:0]               wr_reg,
    output logic [3:0]                wr_reg_addr,
    output logic                      wr_reg_changed,
    input  logic [31:0]               ev_reg,
    output logic                      fpga_irq
);
    host_api_pkg::api_state_e  state;
    host_api_pkg::cmd_e        cmd;
    logic [1:0]                byte_cnt;
    logic [`API_ADDR_BITS-1:0] addr;
    logic [23:0]               reg_buf;
    logic [31:0]               reply_word;
    logic [31:0]               got_reg;
    logic                      ready_en;
    logic                      in_mem_data;
    logic                      reply_pending;
    logic                      accept;
    logic                      last_addr;
    logic                      is_ev;

    assign in_mem_data   = (state == host_api_pkg::DATA) && (cmd == host_api_pkg::CMD_WRITE_MEM);
    assign reply_pending = (state == host_api_pkg::DATA) && (cmd == host_api_pkg::CMD_READ_REG);
    assign host_ready    = ready_en && !reply_pending && !(in_mem_data && byte_fifo_full);
    assign accept        = rd_valid && host_ready;
    assign last_addr     = accept && (state == host_api_pkg::ADDR) && (byte_cnt == 2'd2);
    assign is_ev         = (rd_data[3:0] == 4'(`API_EV_REG_ADDR)); // Low address byte arrives last

    assign byte_push = accept && in_mem_data;
    assign byte_data = rd_data;
    assign word_base = addr[`API_ADDR_BITS-1:1];
    assign wr_data   = reply_word[7:0]; // Reply shifts out low byte first

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= host_api_pkg::IDLE;
            byte_cnt       <= 2'd0;
            wr_valid       <= 1'b0;
            packer_load    <= 1'b0;
            wr_reg_changed <= 1'b0;
            got_reg        <= '0;
            fpga_irq       <= 1'b0;
            ready_en       <= 1'b0;
        end else begin
            ready_en    <= 1'b1;
            packer_load <= 1'b0;
            fpga_irq    <= (got_reg != ev_reg);
            if (start) begin
                state    <= host_api_pkg::CMD; // Abort whatever was in flight
                byte_cnt <= 2'd0;
                wr_valid <= 1'b0;
            end else if (wr_valid) begin
                if (wr_ready) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) begin
                        wr_valid <= 1'b0;
                        state    <= host_api_pkg::IDLE;
                    end
                end
            end else if (accept) begin
                case (state)
                    host_api_pkg::CMD: begin
                        byte_cnt <= 2'd0;
                        state    <= host_api_pkg::ADDR;
                    end
                    host_api_pkg::ADDR: begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_addr) begin
                            byte_cnt    <= 2'd0;
                            state       <= host_api_pkg::DATA;
                            packer_load <= (cmd == host_api_pkg::CMD_WRITE_MEM);
                            if (cmd == host_api_pkg::CMD_READ_REG) begin
                                wr_valid <= 1'b1;
                                if (is_ev) begin
                                    got_reg <= ev_reg; // Same value the reply carries
                                end
                            end
                        end
                    end
                    host_api_pkg::DATA: begin
                        if (cmd == host_api_pkg::CMD_WRITE_REG) begin
                            byte_cnt <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) begin
                                state          <= host_api_pkg::IDLE;
                                wr_reg_changed <= !wr_reg_changed;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!start && accept) begin
            case (state)
                host_api_pkg::CMD: cmd <= host_api_pkg::cmd_e'(rd_data);
                host_api_pkg::ADDR: begin
                    case (byte_cnt)
                        2'd0: addr[`API_ADDR_BITS-1:16] <= rd_data[`API_ADDR_BITS-17:0];
                        2'd1: addr[15:8] <= rd_data;
                        default: addr[7:0] <= rd_data;
                    endcase
                    if (last_addr) begin
                        reply_word <= is_ev ? ev_reg : 32'd0;
                    end
                end
                host_api_pkg::DATA: begin
                    if (cmd == host_api_pkg::CMD_WRITE_REG) begin
                        case (byte_cnt)
                            2'd0: reg_buf[7:0] <= rd_data;
                            2'd1: reg_buf[15:8] <= rd_data;
                            2'd2: reg_buf[23:16] <= rd_data;
                            default: begin
                                wr_reg      <= {rd_data, reg_buf}; // Published only when complete
                                wr_reg_addr <= addr[3:0];
                            end
                        endcase
                    end
                end
                default: begin
                end
            endcase
        end
        if (wr_valid && wr_ready) begin
            reply_word <= {8'd0, reply_word[31:8]};
        end
    end

endmodule

`default_nettype wire

//--- logic/word_packer.sv
`timescale 1ns/1ps
`default_nettype none
`include "host_api_cfg.svh"

module word_packer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      load,
    input  logic [`API_ADDR_BITS-2:0] base,
    input  logic                      byte_empty,
    input  logic [7:0]                byte_data,
    output logic                      byte_pop,
    input  logic                      word_full,
    output logic                      word_push,
    output host_api_pkg::ram_write_t  word_data
);
    logic [7:0]                low_byte;
    logic                      phase; // Set while holding the low half
    logic [`API_ADDR_BITS-2:0] word_addr;

    // A high byte may only leave the FIFO if its word has somewhere to go
    assign byte_pop  = !byte_empty && (!phase || !word_full);
    assign word_push = byte_pop && phase;

    always_comb begin
        word_data.addr = word_addr;
        word_data.data = {byte_data, low_byte};
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            phase <= 1'b0;
        end else if (byte_pop) begin
            phase <= !phase;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_pop && !phase) begin
            low_byte <= byte_data;
        end
        if (load) begin
            word_addr <= base;
        end else if (word_push) begin
            word_addr <= word_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/sdram_issuer.sv
`timescale 1ns/1ps
`default_nettype none
`include "host_api_cfg.svh"

module sdram_issuer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      word_empty,
    input  host_api_pkg::ram_write_t  word_data,
    output logic                      word_pop,
    output logic                      ram_req,
    input  logic                      ram_ack,
    output logic                      ram_we,
    output logic [1:0]                ram_wm,
    output logic [`API_ADDR_BITS-2:0] ram_address,
    output logic [15:0]               ram_data_write
);
    // The controller is idle once its ack has caught up with our req
    assign word_pop = !word_empty && (ram_req == ram_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_req <= 1'b0;
            ram_we  <= 1'b0;
            ram_wm  <= 2'b00;
        end else if (word_pop) begin
            ram_req <= !ram_req;
            ram_we  <= 1'b1;
            ram_wm  <= 2'b00; // Both bytes enabled
        end
    end

    always_ff @(posedge clk) begin
        if (word_pop) begin
            ram_address    <= word_data.addr;
            ram_data_write <= word_data.data;
        end
    end

endmodule

`default_nettype wire

//--- logic/host_api_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "host_api_cfg.svh"

module host_api_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic [7:0]                rd_data,
    input  logic                      rd_valid,
    output logic                      host_ready,
    output logic [7:0]                wr_data,
    output logic                      wr_valid,
    input  logic                      wr_ready,
    output logic [31:0]               wr_reg,
    output logic [3:0]                wr_reg_addr,
    output logic                      wr_reg_changed,
    input  logic [31:0]               ev_reg,
    output logic                      fpga_irq,
    output logic                      ram_req,
    input  logic                      ram_ack,
    output logic                      ram_we,
    output logic [1:0]                ram_wm,
    output logic [`API_ADDR_BITS-2:0] ram_address,
    output logic [15:0]               ram_data_write
);
    logic                      byte_push;
    logic [7:0]                byte_push_data;
    logic                      byte_full;
    logic                      byte_pop;
    logic [7:0]                byte_pop_data;
    logic                      byte_empty;
    logic                      packer_load;
    logic [`API_ADDR_BITS-2:0] word_base;
    logic                      word_push;
    host_api_pkg::ram_write_t  word_push_data;
    logic                      word_full;
    logic                      word_pop;
    host_api_pkg::ram_write_t  word_pop_data;
    logic                      word_empty;

    api_ctrl api_ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .host_ready     (host_ready),
        .byte_fifo_full (byte_full),
        .byte_push      (byte_push),
        .byte_data      (byte_push_data),
        .packer_load    (packer_load),
        .word_base      (word_base),
        .wr_data        (wr_data),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready),
        .wr_reg         (wr_reg),
        .wr_reg_addr    (wr_reg_addr),
        .wr_reg_changed (wr_reg_changed),
        .ev_reg         (ev_reg),
        .fpga_irq       (fpga_irq)
    );

    stream_fifo #(
        .payload_t (logic [7:0]),
        .DEPTH     (`API_BYTE_FIFO_DEPTH)
    ) byte_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (start),
        .push      (byte_push),
        .push_data (byte_push_data),
        .full      (byte_full),
        .pop       (byte_pop),
        .pop_data  (byte_pop_data),
        .empty     (byte_empty)
    );

    word_packer word_packer_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (start),
        .load       (packer_load),
        .base       (word_base),
        .byte_empty (byte_empty),
        .byte_data  (byte_pop_data),
        .byte_pop   (byte_pop),
        .word_full  (word_full),
        .word_push  (word_push),
        .word_data  (word_push_data)
    );

    stream_fifo #(
        .payload_t (host_api_pkg::ram_write_t),
        .DEPTH     (`API_WORD_FIFO_DEPTH)
    ) word_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (start),
        .push      (word_push),
        .push_data (word_push_data),
        .full      (word_full),
        .pop       (word_pop),
        .pop_data  (word_pop_data),
        .empty     (word_empty)
    );

    sdram_issuer sdram_issuer_inst (
        .clk            (clk),
        .reset          (reset),
        .word_empty     (word_empty),
        .word_data      (word_pop_data),
        .word_pop       (word_pop),
        .ram_req        (ram_req),
        .ram_ack        (ram_ack),
        .ram_we         (ram_we),
        .ram_wm         (ram_wm),
        .ram_address    (ram_address),
        .ram_data_write (ram_data_write)
    );

endmodule

`default_nettype wire

//--- bench/tb_host_api.sv
`timescale 1ns/1ps
`default_nettype none
`include "host_api_cfg.svh"

module tb_host_api;
    localparam int WAIT_LIMIT = 200;

    logic                      clk;
    logic                      reset;
    logic                      start;
    logic [7:0]                rd_data;
    logic                      rd_valid;
    logic                      host_ready;
    logic [7:0]                wr_data;
    logic                      wr_valid;
    logic                      wr_ready;
    logic [31:0]               wr_reg;
    logic [3:0]                wr_reg_addr;
    logic                      wr_reg_changed;
    logic [31:0]               ev_reg;
    logic                      fpga_irq;
    logic                      ram_req;
    logic                      ram_ack;
    logic                      ram_we;
    logic [1:0]                ram_wm;
    logic [`API_ADDR_BITS-2:0] ram_address;
    logic [15:0]               ram_data_write;

    logic [31:0] lfsr;
    int          ack_extra; // Added to every ack delay to force back-pressure
    logic        stall_seen;
    logic [31:0] mem_addr_q[$];
    logic [31:0] mem_data_q[$];
    logic [31:0] mem_ctrl_q[$];

    host_api_top host_api_top_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .host_ready     (host_ready),
        .wr_data        (wr_data),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready),
        .wr_reg         (wr_reg),
        .wr_reg_addr    (wr_reg_addr),
        .wr_reg_changed (wr_reg_changed),
        .ev_reg         (ev_reg),
        .fpga_irq       (fpga_irq),
        .ram_req        (ram_req),
        .ram_ack        (ram_ack),
        .ram_we         (ram_we),
        .ram_wm         (ram_wm),
        .ram_address    (ram_address),
        .ram_data_write (ram_data_write)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] value;
        logic       feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value    = {value[6:0], lfsr[31]};
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr     = {lfsr[30:0], feedback};
        end
        return value;
    endfunction

    task automatic drop_rd_valid;
        #1;
        rd_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        #1;
        rd_data  = value;
        rd_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = host_ready;
            if (!host_ready) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            waited++;
            if (!taken && waited > WAIT_LIMIT) begin
                abort_run("Timeout: host_ready stayed low while a byte was offered");
            end
        end
    endtask

    task automatic send_command(input logic [7:0] code, input logic [31:0] addr);
        drop_rd_valid();
        start      = 1'b1;
        stall_seen = 1'b0;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(posedge clk);
        send_byte(code);
        send_byte(addr[23:16]); // Most significant address byte first
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
    endtask

    task automatic expect_reply(input logic [31:0] expected);
        logic [31:0] reply_word;
        logic [7:0]  bits;
        int          got;
        int          waited;
        reply_word = '0;
        got        = 0;
        waited     = 0;
        drop_rd_valid();
        while (got < 4) begin
            bits     = draw_bits(2);
            wr_ready = (bits[1:0] != 2'b00); // Ready three cycles in four
            @(negedge clk);
            if (wr_valid && wr_ready) begin
                reply_word[8*got +: 8] = wr_data;
                got++;
            end
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timeout: the four reply bytes did not arrive on wr_data");
            end
        end
        wr_ready = 1'b0;
        @(negedge clk);
        check_value("wr_valid", 32'(wr_valid), 32'h0); // A reply is exactly four bytes
        @(posedge clk);
        check_value("reply word", reply_word, expected);
    endtask

    task automatic expect_mem(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        drop_rd_valid();
        while (mem_addr_q.size() == 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timeout: an expected SDRAM write was never requested");
            end
        end
        check_value("ram_address", mem_addr_q.pop_front(), addr);
        check_value("ram_data_write", mem_data_q.pop_front(), data);
        check_value("ram_we and ram_wm", mem_ctrl_q.pop_front(), 32'h4);
        @(posedge clk);
    endtask

    task automatic wait_ram_idle;
        int waited;
        waited = 0;
        drop_rd_valid();
        @(negedge clk);
        while (ram_req !== ram_ack) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timeout: the last SDRAM write was never acknowledged");
            end
        end
        @(negedge clk); // A leftover word would have toggled ram_req by now
        check_value("ram_req", 32'(ram_req), 32'(ram_ack));
        check_value("extra SDRAM writes", 32'(mem_addr_q.size()), 32'h0);
    endtask

    // SDRAM controller model with a random completion delay
    initial begin : sdram_model
        logic [7:0] bits;
        int         delay;
        forever begin
            @(negedge clk);
            if (!reset && (ram_req !== ram_ack)) begin
                mem_addr_q.push_back(32'(ram_address));
                mem_data_q.push_back(32'(ram_data_write));
                mem_ctrl_q.push_back(32'({ram_we, ram_wm}));
                bits  = draw_bits(3);
                delay = ack_extra + 1 + int'(bits % 8'd6);
                repeat (delay) @(posedge clk);
                #1;
                ram_ack = !ram_ack;
            end
        end
    end

    initial begin : run_trace
        int               fd;
        int               count;
        logic [63:0]      op;
        logic [8*200-1:0] rest;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        lfsr       = 32'h668aa69f;
        ack_extra  = 0;
        stall_seen = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        rd_data    = 8'h00;
        rd_valid   = 1'b0;
        wr_ready   = 1'b0;
        ev_reg     = 32'h0;
        ram_ack    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("ram_req", 32'(ram_req), 32'h0);
        check_value("wr_valid", 32'(wr_valid), 32'h0);
        check_value("host_ready", 32'(host_ready), 32'h0);
        check_value("fpga_irq", 32'(fpga_irq), 32'h0);
        check_value("wr_reg_changed", 32'(wr_reg_changed), 32'h0);
        @(posedge clk);
        fd = $fopen("bench/api_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file bench/api_trace.txt");
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": count = $fgets(rest, fd);
                "wreg", "rreg", "wmem", "rmem": begin
                    count = $fscanf(fd, "%h", f1);
                    if (op == "wreg") send_command(host_api_pkg::CMD_WRITE_REG, f1);
                    else if (op == "rreg") send_command(host_api_pkg::CMD_READ_REG, f1);
                    else if (op == "wmem") send_command(host_api_pkg::CMD_WRITE_MEM, f1);
                    else send_command(host_api_pkg::CMD_READ_MEM, f1);
                end
                "send": begin
                    count = $fscanf(fd, "%h", f1);
                    for (int i = 0; i < int'(f1); i++) begin
                        count = $fscanf(fd, "%h", f2);
                        send_byte(f2[7:0]);
                    end
                end
                "ev": begin
                    count = $fscanf(fd, "%h", f1);
                    drop_rd_valid();
                    ev_reg = f1;
                    @(posedge clk);
                end
                "irq": begin
                    count = $fscanf(fd, "%h", f1);
                    drop_rd_valid();
                    @(posedge clk); // The interrupt is registered one cycle behind
                    @(negedge clk);
                    check_value("fpga_irq", 32'(fpga_irq), f1);
                    @(posedge clk);
                end
                "reg": begin
                    count = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    drop_rd_valid();
                    @(negedge clk);
                    check_value("wr_reg_addr", 32'(wr_reg_addr), f1);
                    check_value("wr_reg", wr_reg, f2);
                    check_value("wr_reg_changed", 32'(wr_reg_changed), f3);
                    @(posedge clk);
                end
                "reply": begin
                    count = $fscanf(fd, "%h", f1);
                    expect_reply(f1);
                end
                "mem": begin
                    count = $fscanf(fd, "%h %h", f1, f2);
                    expect_mem(f1, f2);
                end
                "slow": begin
                    count = $fscanf(fd, "%h", f1);
                    ack_extra = int'(f1);
                end
                "stall": begin
                    count = $fscanf(fd, "%h", f1);
                    check_value("host_ready stall seen", 32'(stall_seen), f1);
                end
                default: abort_run($sformatf("Unknown operation in the trace file: %0s", op));
            endcase
        end
        $fclose(fd);
        wait_ram_idle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/host_api_pkg.sv
logic/stream_fifo.sv
logic/api_ctrl.sv
logic/word_packer.sv
logic/sdram_issuer.sv
logic/host_api_top.sv
bench/tb_host_api.sv

//--- Makefile
# Verilator build and run for the host command bridge

VERILATOR  ?= verilator
TOP        ?= tb_host_api
LINT_TOP   ?= host_api_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/api_trace.txt
# Columns: op then hex fields. wreg, rreg, wmem, rmem AAAAAA / send NN and NN bytes / ev VVVVVVVV
# irq B / slow NN / stall B / reg A VVVVVVVV T / reply VVVVVVVV / mem AAAAAA DDDD
wreg 000005
send 04 44 33 22 11
reg 5 11223344 1
ev 000000a5
irq 1
rreg 000001
reply 000000a5
irq 0
rreg 000007
reply 00000000
wreg 000009
send 02 aa bb
wreg 00000c
reg 5 11223344 1
send 04 01 02 03 04
reg c 04030201 0
rmem 000000
send 02 55 66
slow 10
wmem 001020
send 0c 10 11 12 13 14 15 16 17 18 19 1a 1b
send 0c 1c 1d 1e 1f 20 21 22 23 24 25 26 27
stall 1
mem 000810 1110
mem 000811 1312
mem 000812 1514
mem 000813 1716
mem 000814 1918
mem 000815 1b1a
mem 000816 1d1c
mem 000817 1f1e
mem 000818 2120
mem 000819 2322
mem 00081a 2524
mem 00081b 2726
